// ==== verilog/ex_pkg.sv ====
package ex_pkg;

    // widths
    localparam int WORD_W     = 32;
    localparam int SHAMT_W    = 5;
    localparam int REG_ADDR_W = 5;
    localparam int OP_W       = 4;

    // number of execute lanes in flight
    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = $clog2(NUM_LANES);

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OP_W-1:0]       alu_op_t;
    typedef logic [LANE_IDX_W-1:0] lane_idx_t;

    // logic
    localparam alu_op_t OP_OR   = 4'd0;
    localparam alu_op_t OP_AND  = 4'd1;
    localparam alu_op_t OP_NOR  = 4'd2;
    localparam alu_op_t OP_XOR  = 4'd3;
    // shift
    localparam alu_op_t OP_SLL  = 4'd4;
    localparam alu_op_t OP_SRL  = 4'd5;
    localparam alu_op_t OP_SRA  = 4'd6;
    // add and subtract
    localparam alu_op_t OP_ADD  = 4'd7;
    localparam alu_op_t OP_ADDU = 4'd8;
    localparam alu_op_t OP_SUB  = 4'd9;
    localparam alu_op_t OP_SUBU = 4'd10;
    // compare
    localparam alu_op_t OP_SLT  = 4'd11;
    localparam alu_op_t OP_SLTU = 4'd12;
    // bit counts
    localparam alu_op_t OP_CLZ  = 4'd13;
    localparam alu_op_t OP_CLO  = 4'd14;
    // low word of the signed product
    localparam alu_op_t OP_MUL  = 4'd15;

    // one instruction entering the execute stage
    typedef struct packed {
        alu_op_t   op;
        word_t     operand_1;
        word_t     operand_2;
        reg_addr_t reg_write_addr;
        logic      reg_write_en;
    } exe_req_t;

    // write-back result of one instruction
    typedef struct packed {
        word_t     reg_write_data;
        reg_addr_t reg_write_addr;
        logic      reg_write_en;
    } exe_res_t;

endpackage

// ==== verilog/ex_alu.sv ====
module ex_alu (
    input  ex_pkg::alu_op_t op_i,
    input  ex_pkg::word_t   operand_1_i,
    input  ex_pkg::word_t   operand_2_i,
    output ex_pkg::word_t   result_o,
    output logic            overflow_o
);

    import ex_pkg::*;

    shamt_t shamt;
    word_t  operand_2_mux;
    word_t  sum;
    word_t  operand_1_not;
    word_t  clz_count;
    word_t  clo_count;
    logic   negate;
    logic   sum_overflow;
    logic   signed_lt;
    logic   unsigned_lt;
    logic signed [2*WORD_W-1:0] product;

    function automatic word_t count_lead_zeros(input word_t value);
        word_t count;
        logic  seen_one;
        count    = '0;
        seen_one = 1'b0;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            if (value[i]) begin
                seen_one = 1'b1;
            end else if (!seen_one) begin
                count = count + 1'b1;
            end
        end
        return count;
    endfunction

    // shift amount comes from operand 1
    assign shamt = operand_1_i[SHAMT_W-1:0];

    assign negate = (op_i == OP_SUB) || (op_i == OP_SUBU) || (op_i == OP_SLT);
    assign operand_2_mux = negate ? (~operand_2_i + 1'b1) : operand_2_i;
    assign sum = operand_1_i + operand_2_mux;

    // same-sign inputs, different-sign sum
    assign sum_overflow = (operand_1_i[WORD_W-1] == operand_2_mux[WORD_W-1])
                       && (sum[WORD_W-1] != operand_1_i[WORD_W-1]);
    assign overflow_o = sum_overflow && ((op_i == OP_ADD) || (op_i == OP_SUB));

    // less than when only operand 1 is negative or equal signs give a negative difference
    assign signed_lt = (operand_1_i[WORD_W-1] && !operand_2_i[WORD_W-1])
                    || ((operand_1_i[WORD_W-1] == operand_2_i[WORD_W-1]) && sum[WORD_W-1]);
    assign unsigned_lt = operand_1_i < operand_2_i;

    assign operand_1_not = ~operand_1_i;
    assign clz_count = count_lead_zeros(operand_1_i);
    assign clo_count = count_lead_zeros(operand_1_not);

    assign product = $signed(operand_1_i) * $signed(operand_2_i);

    always_comb begin
        case (op_i)
            OP_OR:   result_o = operand_1_i | operand_2_i;
            OP_AND:  result_o = operand_1_i & operand_2_i;
            OP_NOR:  result_o = ~(operand_1_i | operand_2_i);
            OP_XOR:  result_o = operand_1_i ^ operand_2_i;
            OP_SLL:  result_o = operand_2_i << shamt;
            OP_SRL:  result_o = operand_2_i >> shamt;
            OP_SRA:  result_o = word_t'($signed(operand_2_i) >>> shamt);
            OP_ADD,
            OP_ADDU,
            OP_SUB,
            OP_SUBU: result_o = sum;
            OP_SLT:  result_o = word_t'(signed_lt);
            OP_SLTU: result_o = word_t'(unsigned_lt);
            OP_CLZ:  result_o = clz_count;
            OP_CLO:  result_o = clo_count;
            OP_MUL:  result_o = product[WORD_W-1:0];
            default: result_o = '0;
        endcase
    end

endmodule

// ==== verilog/ex_lane.sv ====
module ex_lane (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             issue_i,
    input  ex_pkg::exe_req_t issue_data_i,
    input  logic             release_i,
    output logic             busy_o,
    output logic             done_o,
    output ex_pkg::exe_res_t result_o
);

    import ex_pkg::*;

    exe_req_t req_q;
    word_t    alu_result;
    logic     alu_overflow;
    logic     compute;

    ex_alu ex_alu_inst (
        .op_i        (req_q.op),
        .operand_1_i (req_q.operand_1),
        .operand_2_i (req_q.operand_2),
        .result_o    (alu_result),
        .overflow_o  (alu_overflow)
    );

    // one cycle between capture and result
    assign compute = busy_o && !done_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
        end else if (issue_i) begin
            busy_o <= 1'b1;
        end else if (release_i) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
        end else if (compute) begin
            done_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            req_q <= issue_data_i;
        end
        if (compute) begin
            result_o.reg_write_data <= alu_result;
            result_o.reg_write_addr <= req_q.reg_write_addr;
            // signed overflow cancels the write
            result_o.reg_write_en   <= req_q.reg_write_en && !alu_overflow;
        end
    end

endmodule

// ==== verilog/ex_dispatch.sv ====
module ex_dispatch (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         req_i,
    input  ex_pkg::exe_req_t             req_data_i,
    output logic                         ack_o,
    input  logic [ex_pkg::NUM_LANES-1:0] busy_i,
    output logic [ex_pkg::NUM_LANES-1:0] issue_o,
    output ex_pkg::exe_req_t             issue_data_o
);

    import ex_pkg::*;

    typedef enum logic {
        DSP_IDLE,
        DSP_ACK
    } dsp_state_t;

    dsp_state_t state;
    lane_idx_t  lane_ptr;
    lane_idx_t  lane_ptr_next;

    // round-robin wrap
    assign lane_ptr_next = (lane_ptr == lane_idx_t'(NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state    <= DSP_IDLE;
            lane_ptr <= '0;
            ack_o    <= 1'b0;
            issue_o  <= '0;
        end else begin
            // issue is a single-cycle pulse
            issue_o <= '0;
            case (state)
                DSP_IDLE: begin
                    // wait for the target lane to drain
                    if (req_i && !busy_i[lane_ptr]) begin
                        ack_o             <= 1'b1;
                        issue_o[lane_ptr] <= 1'b1;
                        state             <= DSP_ACK;
                    end
                end
                DSP_ACK: begin
                    if (!req_i) begin
                        ack_o    <= 1'b0;
                        lane_ptr <= lane_ptr_next;
                        state    <= DSP_IDLE;
                    end
                end
                default: begin
                    state <= DSP_IDLE;
                end
            endcase
        end
    end

    // shared request register seen by all lanes
    always_ff @(posedge clk) begin
        if (state == DSP_IDLE && req_i && !busy_i[lane_ptr]) begin
            issue_data_o <= req_data_i;
        end
    end

endmodule

// ==== verilog/ex_collect.sv ====
module ex_collect (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic [ex_pkg::NUM_LANES-1:0]             done_i,
    input  ex_pkg::exe_res_t [ex_pkg::NUM_LANES-1:0] result_i,
    output logic [ex_pkg::NUM_LANES-1:0]             release_o,
    output logic                                     res_req_o,
    output ex_pkg::exe_res_t                         res_data_o,
    input  logic                                     res_ack_i
);

    import ex_pkg::*;

    typedef enum logic [1:0] {
        COL_WAIT,
        COL_REQ,
        COL_DROP
    } col_state_t;

    col_state_t state;
    lane_idx_t  lane_ptr;
    lane_idx_t  lane_ptr_next;
    logic       take;

    // lanes drain in the order the dispatcher filled them
    assign lane_ptr_next = (lane_ptr == lane_idx_t'(NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;
    assign take = (state == COL_WAIT) && done_i[lane_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state     <= COL_WAIT;
            lane_ptr  <= '0;
            res_req_o <= 1'b0;
            release_o <= '0;
        end else begin
            release_o <= '0;
            case (state)
                COL_WAIT: begin
                    if (take) begin
                        res_req_o <= 1'b1;
                        state     <= COL_REQ;
                    end
                end
                COL_REQ: begin
                    if (res_ack_i) begin
                        res_req_o           <= 1'b0;
                        release_o[lane_ptr] <= 1'b1;
                        state               <= COL_DROP;
                    end
                end
                COL_DROP: begin
                    // receiver must drop ack before the next word
                    if (!res_ack_i) begin
                        lane_ptr <= lane_ptr_next;
                        state    <= COL_WAIT;
                    end
                end
                default: begin
                    state <= COL_WAIT;
                end
            endcase
        end
    end

    // held steady for the whole request phase
    always_ff @(posedge clk) begin
        if (take) begin
            res_data_o <= result_i[lane_ptr];
        end
    end

endmodule

// ==== verilog/ex_top.sv ====
module ex_top (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             req_i,
    input  ex_pkg::exe_req_t req_data_i,
    output logic             ack_o,
    output logic             res_req_o,
    output ex_pkg::exe_res_t res_data_o,
    input  logic             res_ack_i
);

    import ex_pkg::*;

    logic [NUM_LANES-1:0]     lane_issue;
    logic [NUM_LANES-1:0]     lane_busy;
    logic [NUM_LANES-1:0]     lane_done;
    logic [NUM_LANES-1:0]     lane_release;
    exe_req_t                 issue_data;
    exe_res_t [NUM_LANES-1:0] lane_result;

    ex_dispatch ex_dispatch_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .req_data_i   (req_data_i),
        .ack_o        (ack_o),
        .busy_i       (lane_busy),
        .issue_o      (lane_issue),
        .issue_data_o (issue_data)
    );

    // identical lanes, all fed from the shared request register
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        ex_lane ex_lane_inst (
            .clk          (clk),
            .rst_n_i      (rst_n_i),
            .issue_i      (lane_issue[g]),
            .issue_data_i (issue_data),
            .release_i    (lane_release[g]),
            .busy_o       (lane_busy[g]),
            .done_o       (lane_done[g]),
            .result_o     (lane_result[g])
        );
    end

    ex_collect ex_collect_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .done_i     (lane_done),
        .result_i   (lane_result),
        .release_o  (lane_release),
        .res_req_o  (res_req_o),
        .res_data_o (res_data_o),
        .res_ack_i  (res_ack_i)
    );

endmodule

// ==== tests/ex_model.svh ====
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// expected write-back for one request, from the execute rules
function automatic exe_res_t model_execute(input exe_req_t req);
    exe_res_t    res;
    word_t       a;
    word_t       b;
    word_t       neg_b;
    logic [32:0] wide;
    logic        overflow;
    longint      prod;
    int          count;
    a        = req.operand_1;
    b        = req.operand_2;
    neg_b    = -b;
    overflow = 1'b0;
    count    = 0;
    wide     = '0;
    prod     = 0;
    res.reg_write_data = '0;
    case (req.op)
        OP_OR:   res.reg_write_data = a | b;
        OP_AND:  res.reg_write_data = a & b;
        OP_NOR:  res.reg_write_data = ~(a | b);
        OP_XOR:  res.reg_write_data = a ^ b;
        OP_SLL:  res.reg_write_data = b << a[4:0];
        OP_SRL:  res.reg_write_data = b >> a[4:0];
        OP_SRA:  res.reg_write_data = word_t'($signed(b) >>> a[4:0]);
        OP_ADD, OP_ADDU: begin
            // sign-extended sum overflows when its top two bits disagree
            wide     = {a[31], a} + {b[31], b};
            res.reg_write_data = wide[31:0];
            overflow = wide[32] != wide[31];
        end
        OP_SUB, OP_SUBU: begin
            wide     = {a[31], a} + {neg_b[31], neg_b};
            res.reg_write_data = wide[31:0];
            overflow = wide[32] != wide[31];
        end
        OP_SLT:  res.reg_write_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        OP_SLTU: res.reg_write_data = (a < b) ? 32'd1 : 32'd0;
        OP_CLZ: begin
            while (count < 32 && !a[31 - count]) begin
                count++;
            end
            res.reg_write_data = word_t'(count);
        end
        OP_CLO: begin
            while (count < 32 && a[31 - count]) begin
                count++;
            end
            res.reg_write_data = word_t'(count);
        end
        OP_MUL: begin
            prod = longint'($signed(a)) * longint'($signed(b));
            res.reg_write_data = prod[31:0];
        end
        default: res.reg_write_data = '0;
    endcase
    res.reg_write_addr = req.reg_write_addr;
    res.reg_write_en   = req.reg_write_en
                      && !(overflow && (req.op == OP_ADD || req.op == OP_SUB));
    return res;
endfunction

`endif

// ==== tests/tb_ex_top.sv ====
module tb_ex_top;

    timeunit 1ns;
    timeprecision 1ps;

    import ex_pkg::*;

    `include "ex_model.svh"

    localparam int NUM_TRANS        = 400;
    localparam int CYCLES_PER_TRANS = 20;
    localparam int TIMEOUT_CYCLES   = NUM_TRANS * CYCLES_PER_TRANS;

    logic     clk;
    logic     rst_n_i;
    logic     req_i;
    exe_req_t req_data_i;
    logic     ack_o;
    logic     res_req_o;
    exe_res_t res_data_o;
    logic     res_ack_i;

    exe_res_t expected_q[$];
    integer   seed;
    int       cycle_count = 0;
    int       received;

    ex_top ex_top_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .req_data_i (req_data_i),
        .ack_o      (ack_o),
        .res_req_o  (res_req_o),
        .res_data_o (res_data_o),
        .res_ack_i  (res_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d results received", cycle_count, received);
            $display("Verification failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    function automatic word_t pick_edge_value(input logic [31:0] r);
        case (r % 3)
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            default: return 32'h8000_0000;
        endcase
    endfunction

    // directed sweeps over every op first, then random ops and operand modes
    task automatic build_request(input int idx, output exe_req_t req);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        int          mode;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        if (idx < 64) begin
            req.op = alu_op_t'(idx % 16);
            mode   = idx / 16;
        end else if (idx < 64 + 16 * 9) begin
            // every op on every pair of edge values
            req.op = alu_op_t'(idx % 16);
            mode   = 1;
            r1     = (idx - 64) / 48;
            r2     = ((idx - 64) / 16) % 3;
        end else begin
            req.op = alu_op_t'(r3[3:0]);
            mode   = int'(r3[6:4]);
        end
        req.operand_1      = r1;
        req.operand_2      = r2;
        req.reg_write_addr = r3[12:8];
        req.reg_write_en   = r3[13];
        case (mode)
            1: begin
                req.operand_1 = pick_edge_value(r1);
                req.operand_2 = pick_edge_value(r2);
            end
            2: begin
                // large positive operands push add and sub past the signed range
                req.operand_1 = {2'b01, r1[29:0]};
                if (req.op == OP_SUB || req.op == OP_SUBU) begin
                    req.operand_2 = {2'b10, r2[29:0]};
                end else begin
                    req.operand_2 = {2'b01, r2[29:0]};
                end
                req.reg_write_en = 1'b1;
            end
            3: begin
                // negative operand 2 against a positive operand 1
                req.operand_1 = {1'b0, r1[30:0]};
                req.operand_2 = {1'b1, r2[30:0]};
            end
            default: begin
            end
        endcase
    endtask

    task automatic drive_requests();
        exe_req_t req;
        int       gap;
        for (int i = 0; i < NUM_TRANS; i++) begin
            build_request(i, req);
            gap = {$random(seed)} % 4;
            repeat (gap) @(negedge clk);
            req_data_i = req;
            req_i      = 1'b1;
            do begin
                @(negedge clk);
            end while (!ack_o);
            expected_q.push_back(model_execute(req));
            req_i = 1'b0;
            do begin
                @(negedge clk);
            end while (ack_o);
        end
    endtask

    task automatic collect_results();
        exe_res_t expected;
        int       delay;
        while (received < NUM_TRANS) begin
            do begin
                @(negedge clk);
            end while (!res_req_o);
            delay = {$random(seed)} % 9;
            repeat (delay) @(negedge clk);
            if (expected_q.size() == 0) begin
                $display("a result arrived with no request pending at %0t", $time);
                $display("Verification failed");
                $fatal(1);
            end
            expected = expected_q.pop_front();
            check_value("reg_write_data", 64'(expected.reg_write_data),
                        64'(res_data_o.reg_write_data));
            check_value("reg_write_addr", 64'(expected.reg_write_addr),
                        64'(res_data_o.reg_write_addr));
            check_value("reg_write_en", 64'(expected.reg_write_en),
                        64'(res_data_o.reg_write_en));
            res_ack_i = 1'b1;
            do begin
                @(negedge clk);
            end while (res_req_o);
            res_ack_i = 1'b0;
            received++;
        end
    endtask

    initial begin
        seed       = 32'hb0e9_8353;
        rst_n_i    = 1'b0;
        req_i      = 1'b0;
        req_data_i = '0;
        res_ack_i  = 1'b0;
        received   = 0;
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        check_value("ack_o", 64'(1'b0), 64'(ack_o));
        check_value("res_req_o", 64'(1'b0), 64'(res_req_o));
        fork
            drive_requests();
            collect_results();
        join
        // no extra result may follow the last one
        repeat (20) @(negedge clk);
        check_value("res_req_o", 64'(1'b0), 64'(res_req_o));
        if (expected_q.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("%0d expected results never arrived", expected_q.size());
            $display("Verification failed");
            $fatal(1);
        end
    end

endmodule

// ==== project.f ====
+incdir+tests
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_lane.sv
verilog/ex_dispatch.sv
verilog/ex_collect.sv
verilog/ex_top.sv
tests/tb_ex_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps -f project.f \
    --top-module tb_ex_top -o sim_tb_ex_top --Mdir obj_dir > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb_ex_top > sim.log 2>&1
cat sim.log
grep -q "^Verification passed$" sim.log && echo "PASS" \
    || { echo "FAIL"; exit 1; }
